//--- Bender.yml
package:
  name: timer

sources:
  - rtl/timer_pkg.sv
  - rtl/timer_prescaler.sv
  - rtl/timer_counter.sv
  - rtl/timer_regs.sv
  - rtl/timer_top.sv
  - target: test
    files:
      - tb/timer_tb.sv

//--- list.f
rtl/timer_pkg.sv
rtl/timer_prescaler.sv
rtl/timer_counter.sv
rtl/timer_regs.sv
rtl/timer_top.sv
tb/timer_tb.sv

//--- rtl/timer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module timer_counter
   (
   input  wire logic                          clk,
   input  wire logic                          io_clk,
   // one pulse per prescaler period, already qualified by enable
   input  wire logic                          tick,
   // software load
   input  wire logic                          cnt_load,
   input  wire logic [timer_pkg::DATA_W-1:0]  load_val,
   // auto-reload limit
   input  wire logic [timer_pkg::DATA_W-1:0]  arr,
   output logic      [timer_pkg::DATA_W-1:0]  count,
   output logic                               match
   );

   // count sits on the reload limit
   logic at_arr;

   // value for the next edge
   logic [timer_pkg::DATA_W-1:0] count_nxt;

   assign at_arr = (count == arr);

   // wrap pulse, comes from the compare ahead of the edge
   // a load in the same cycle overrides the wrap
   assign match = tick & at_arr & ~cnt_load;

   // next count selection
   // load first, then wrap or increment on tick
   always_comb
   begin
      count_nxt = count;
      if (cnt_load)
      begin
         count_nxt = load_val;
      end
      else if (tick)
      begin
         if (at_arr)
         begin
            count_nxt = '0;
         end
         else
         begin
            count_nxt = count + 1'b1;
         end
      end
   end

   // timer value register
   always_ff @(posedge clk or posedge io_clk)
   begin
      if (io_clk)
      begin
         count <= '0;
      end
      else
      begin
         count <= count_nxt;
      end
   end

endmodule

`default_nettype wire

//--- rtl/timer_pkg.sv
`default_nettype none

package timer_pkg;

   // data path and counter width
   localparam int DATA_W = 32;

   // apb byte address width, registers sit on word boundaries
   localparam int ADDR_W = 5;

   // register map, byte offsets
   typedef enum logic [ADDR_W-1:0] {
      REG_CTRL  = 5'h00,
      REG_PRESC = 5'h04,
      REG_ARR   = 5'h08,
      REG_CNT   = 5'h0C,
      REG_STAT  = 5'h10
   } reg_addr_e;

   // control word fields
   localparam int CTRL_EN_BIT = 0;
   localparam int CTRL_IE_BIT = 1;

   // status word fields
   // run mirrors the enable bit
   localparam int STAT_RUN_BIT = 0;
   // sticky overflow, write one to clear
   localparam int STAT_OVF_BIT = 1;

endpackage

`default_nettype wire

//--- rtl/timer_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler
   (
   input  wire logic                          clk,
   input  wire logic                          io_clk,
   input  wire logic                          cnt_en,
   input  wire logic                          cnt_load,
   input  wire logic [timer_pkg::DATA_W-1:0]  presc,
   output logic                               tick
   );

   // cycles left until the next tick
   logic [timer_pkg::DATA_W-1:0] div;

   // divider is held at presc while idle or on a load
   // so the first tick comes presc+1 cycles later
   always_ff @(posedge clk or posedge io_clk)
   begin
      if (io_clk)
      begin
         div  <= '0;
         tick <= 1'b0;
      end
      else if (!cnt_en || cnt_load)
      begin
         // restart a full period
         div  <= presc;
         tick <= 1'b0;
      end
      else if (div == '0)
      begin
         // period done, reload and fire
         div  <= presc;
         tick <= 1'b1;
      end
      else
      begin
         div  <= div - 1'b1;
         tick <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- rtl/timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_regs
   (
   input  wire logic                          clk,
   input  wire logic                          io_clk,
   // apb slave side
   input  wire logic                          psel,
   input  wire logic                          penable,
   input  wire logic                          pwrite,
   input  wire logic [timer_pkg::ADDR_W-1:0]  paddr,
   input  wire logic [timer_pkg::DATA_W-1:0]  pwdata,
   output logic      [timer_pkg::DATA_W-1:0]  prdata,
   output logic                               pslverr,
   // from the counter
   input  wire logic [timer_pkg::DATA_W-1:0]  count,
   input  wire logic                          match,
   // to prescaler and counter
   output logic                               cnt_en,
   output logic      [timer_pkg::DATA_W-1:0]  presc,
   output logic      [timer_pkg::DATA_W-1:0]  arr,
   output logic                               cnt_load,
   output logic      [timer_pkg::DATA_W-1:0]  load_val,
   // interrupt line
   output logic                               irq
   );

   // access phase qualifiers
   logic access;
   logic wr_acc;
   logic rd_acc;

   // decoded register hits
   logic addr_hit;
   logic wr_ctrl;
   logic wr_presc;
   logic wr_arr;
   logic wr_stat;

   // interrupt enable, the only control bit not exported
   logic irq_en;

   // sticky overflow flag
   logic ovf;

   // read mux result before the access qualifier
   logic [timer_pkg::DATA_W-1:0] rd_word;

   // ovf clear request from software
   logic ovf_clr;

   // second cycle of an apb transfer
   assign access = psel & penable;
   assign wr_acc = access & pwrite;
   assign rd_acc = access & ~pwrite;

   // address decode and read data selection
   always_comb
   begin
      addr_hit = 1'b1;
      rd_word  = '0;
      case (paddr)
         timer_pkg::REG_CTRL:
         begin
            rd_word[timer_pkg::CTRL_EN_BIT] = cnt_en;
            rd_word[timer_pkg::CTRL_IE_BIT] = irq_en;
         end
         timer_pkg::REG_PRESC:
         begin
            rd_word = presc;
         end
         timer_pkg::REG_ARR:
         begin
            rd_word = arr;
         end
         timer_pkg::REG_CNT:
         begin
            // live value straight from the counter
            rd_word = count;
         end
         timer_pkg::REG_STAT:
         begin
            rd_word[timer_pkg::STAT_RUN_BIT] = cnt_en;
            rd_word[timer_pkg::STAT_OVF_BIT] = ovf;
         end
         default:
         begin
            // unmapped offset
            addr_hit = 1'b0;
         end
      endcase
   end

   // per register write strobes, only on mapped offsets
   assign wr_ctrl  = wr_acc & (paddr == timer_pkg::REG_CTRL);
   assign wr_presc = wr_acc & (paddr == timer_pkg::REG_PRESC);
   assign wr_arr   = wr_acc & (paddr == timer_pkg::REG_ARR);
   assign wr_stat  = wr_acc & (paddr == timer_pkg::REG_STAT);

   // direct counter load, lands at the edge ending the access
   assign cnt_load = wr_acc & (paddr == timer_pkg::REG_CNT);
   assign load_val = pwdata;

   // read data only while the access cycle is up
   assign prdata  = rd_acc ? rd_word : '0;

   // error for any access to a hole in the map
   assign pslverr = access & ~addr_hit;

   // control, prescaler and reload registers
   always_ff @(posedge clk or posedge io_clk)
   begin
      if (io_clk)
      begin
         cnt_en <= 1'b0;
         irq_en <= 1'b0;
         presc  <= '0;
         arr    <= '0;
      end
      else
      begin
         if (wr_ctrl)
         begin
            cnt_en <= pwdata[timer_pkg::CTRL_EN_BIT];
            irq_en <= pwdata[timer_pkg::CTRL_IE_BIT];
         end
         if (wr_presc)
         begin
            presc <= pwdata;
         end
         if (wr_arr)
         begin
            arr <= pwdata;
         end
      end
   end

   // write one to the ovf bit of status
   assign ovf_clr = wr_stat & pwdata[timer_pkg::STAT_OVF_BIT];

   // overflow flag
   // a match in the same cycle beats the clear
   always_ff @(posedge clk or posedge io_clk)
   begin
      if (io_clk)
      begin
         ovf <= 1'b0;
      end
      else if (match)
      begin
         ovf <= 1'b1;
      end
      else if (ovf_clr)
      begin
         ovf <= 1'b0;
      end
   end

   // level interrupt, follows the flag when enabled
   assign irq = ovf & irq_en;

endmodule

`default_nettype wire

//--- rtl/timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module timer_top
   (
   input  wire logic                          clk,
   // active high async reset
   input  wire logic                          io_clk,
   // apb slave port
   input  wire logic                          psel,
   input  wire logic                          penable,
   input  wire logic                          pwrite,
   input  wire logic [timer_pkg::ADDR_W-1:0]  paddr,
   input  wire logic [timer_pkg::DATA_W-1:0]  pwdata,
   output logic      [timer_pkg::DATA_W-1:0]  prdata,
   output logic                               pready,
   output logic                               pslverr,
   // interrupt and live counter value
   output logic                               irq,
   output logic      [timer_pkg::DATA_W-1:0]  count
   );

   // register block controls
   logic                         cnt_en;
   logic [timer_pkg::DATA_W-1:0] presc;
   logic [timer_pkg::DATA_W-1:0] arr;
   logic                         cnt_load;
   logic [timer_pkg::DATA_W-1:0] load_val;

   // prescaler to counter
   logic tick;

   // counter back to the register block
   logic match;

   // no wait states
   assign pready = 1'b1;

   timer_regs u_regs
      (
      .clk      (clk),
      .io_clk   (io_clk),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pslverr  (pslverr),
      .count    (count),
      .match    (match),
      .cnt_en   (cnt_en),
      .presc    (presc),
      .arr      (arr),
      .cnt_load (cnt_load),
      .load_val (load_val),
      .irq      (irq)
      );

   timer_prescaler u_presc
      (
      .clk      (clk),
      .io_clk   (io_clk),
      .cnt_en   (cnt_en),
      .cnt_load (cnt_load),
      .presc    (presc),
      .tick     (tick)
      );

   timer_counter u_counter
      (
      .clk      (clk),
      .io_clk   (io_clk),
      .tick     (tick),
      .cnt_load (cnt_load),
      .load_val (load_val),
      .arr      (arr),
      .count    (count),
      .match    (match)
      );

endmodule

`default_nettype wire

//--- tb/timer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module timer_tb;

   // longest run is four counting passes of about 120 clocks plus register tests
   localparam int MAX_CYCLES = 4000;
   localparam int N_RUNS = 4;
   localparam int NO_STOP = 1000000;

   logic                         clk;
   logic                         io_clk;
   logic                         psel;
   logic                         penable;
   logic                         pwrite;
   logic [timer_pkg::ADDR_W-1:0] paddr;
   logic [timer_pkg::DATA_W-1:0] pwdata;
   logic [timer_pkg::DATA_W-1:0] prdata;
   logic                         pready;
   logic                         pslverr;
   logic                         irq;
   logic [timer_pkg::DATA_W-1:0] count;

   int   errors;
   int   cycles;
   logic last_err;

   // model state for the comparing process
   logic mon_active;
   logic mon_ie;
   int   mon_k;
   int   mon_stop_k;
   int   mon_eff;
   int   mon_load;
   int   mon_presc;
   int   mon_arr;

   timer_top DUT
      (
      .clk     (clk),
      .io_clk  (io_clk),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq),
      .count   (count)
      );

   // 100 ns clock
   always #50 clk = ~clk;

   // ticks seen by the counter after a number of edges from enable or load
   // first tick lands presc+2 edges in, then one every presc+1
   function automatic int tick_total(input int presc, input int edges);
      if (edges < 1)
         return 0;
      return (edges - 1) / (presc + 1);
   endfunction

   // count wraps to zero after arr, so it walks a ring of arr+1 values
   function automatic int expected_count(input int load, input int presc, input int arr,
                                         input int edges);
      return (load + tick_total(presc, edges)) % (arr + 1);
   endfunction

   // overflow flag, set once the ring has been passed; load is never above arr
   function automatic int expected_ovf(input int load, input int presc, input int arr,
                                       input int edges);
      return ((load + tick_total(presc, edges)) > arr) ? 1 : 0;
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
      if (act_val !== exp_val)
      begin
         errors = errors + 1;
         $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
      end
   endtask

   // setup then access, driven on falling edges, sampled late in the access cycle
   task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #40;
      last_err = pslverr;
      // no wait states
      check_word("pready", 1'b1, pready);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #40;
      data = prdata;
      err  = pslverr;
      check_word("pready", 1'b1, pready);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // read of a mapped register, no slave error expected
   task automatic read_check(input logic [4:0] addr, input logic [31:0] exp_val,
                             input string name);
      logic [31:0] rd;
      logic        err;
      apb_read(addr, rd, err);
      check_word(name, exp_val, rd);
      check_word("pslverr", 1'b0, err);
   endtask

   // comparing process, just after each rising edge
   // enable drop at edge stop_k still lets one pending tick through
   always @(posedge clk)
   begin
      #1;
      if (mon_active)
      begin
         mon_k = mon_k + 1;
         mon_eff = (mon_k < mon_stop_k + 1) ? mon_k : mon_stop_k + 1;
         check_word("count", expected_count(mon_load, mon_presc, mon_arr, mon_eff), count);
         check_word("irq", mon_ie ? expected_ovf(mon_load, mon_presc, mon_arr, mon_eff) : 0,
                    irq);
      end
   end

   // watchdog
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] rd;
      logic        err;
      logic [31:0] wr_presc;
      logic [31:0] wr_arr;
      logic [31:0] wr_ctrl;
      int          seed;
      seed = $urandom(38791);
      errors = 0;
      cycles = 0;
      clk = 1'b0;
      io_clk = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      last_err = 1'b0;
      mon_active = 1'b0;
      mon_ie = 1'b0;
      mon_k = 0;
      mon_stop_k = NO_STOP;
      mon_eff = 0;
      mon_load = 0;
      mon_presc = 0;
      mon_arr = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      io_clk = 1'b0;

      // reset values
      check_word("irq", 1'b0, irq);
      check_word("count", 0, count);
      read_check(timer_pkg::REG_CTRL, 0, "prdata CTRL");
      read_check(timer_pkg::REG_PRESC, 0, "prdata PRESC");
      read_check(timer_pkg::REG_ARR, 0, "prdata ARR");
      read_check(timer_pkg::REG_CNT, 0, "prdata CNT");
      read_check(timer_pkg::REG_STAT, 0, "prdata STAT");

      // register readback and the hole at 0x14
      wr_presc = $urandom;
      wr_arr = $urandom;
      wr_ctrl = $urandom;
      apb_write(timer_pkg::REG_PRESC, wr_presc);
      check_word("pslverr", 1'b0, last_err);
      apb_write(timer_pkg::REG_ARR, wr_arr);
      check_word("pslverr", 1'b0, last_err);
      apb_write(timer_pkg::REG_CTRL, wr_ctrl);
      check_word("pslverr", 1'b0, last_err);
      read_check(timer_pkg::REG_PRESC, wr_presc, "prdata PRESC");
      read_check(timer_pkg::REG_ARR, wr_arr, "prdata ARR");
      read_check(timer_pkg::REG_CTRL, wr_ctrl & 32'h3, "prdata CTRL");
      apb_write(5'h14, $urandom);
      check_word("pslverr", 1'b1, last_err);
      apb_read(5'h14, rd, err);
      check_word("pslverr", 1'b1, err);
      check_word("prdata 0x14", 0, rd);

      // counting, overflow and interrupt, ie on odd runs
      for (int run = 0; run < N_RUNS; run++)
      begin
         mon_presc = $urandom % 4;
         mon_arr = 2 + $urandom % 8;
         mon_ie = (run % 2 == 1);
         mon_load = 0;
         apb_write(timer_pkg::REG_CTRL, 0);
         apb_write(timer_pkg::REG_STAT, 1 << timer_pkg::STAT_OVF_BIT);
         apb_write(timer_pkg::REG_PRESC, mon_presc);
         apb_write(timer_pkg::REG_ARR, mon_arr);
         apb_write(timer_pkg::REG_CNT, 0);
         apb_write(timer_pkg::REG_CTRL, (1 << timer_pkg::CTRL_EN_BIT) |
                   (mon_ie << timer_pkg::CTRL_IE_BIT));
         mon_k = 0;
         mon_stop_k = NO_STOP;
         mon_active = 1'b1;
         // two full wraps and a bit
         repeat (2 * (mon_presc + 1) * (mon_arr + 1) + mon_presc + 2) @(negedge clk);
         mon_active = 1'b0;
         read_check(timer_pkg::REG_STAT, 32'h3, "prdata STAT");
         check_word("irq", mon_ie, irq);
         // stop first so no match can race the clear
         apb_write(timer_pkg::REG_CTRL, mon_ie << timer_pkg::CTRL_IE_BIT);
         apb_write(timer_pkg::REG_STAT, 1 << timer_pkg::STAT_OVF_BIT);
         check_word("irq", 1'b0, irq);
         read_check(timer_pkg::REG_STAT, 0, "prdata STAT");
      end

      // direct load while running, then hold
      mon_presc = $urandom % 4;
      mon_arr = 2 + $urandom % 8;
      mon_ie = 1'b0;
      mon_load = 0;
      apb_write(timer_pkg::REG_PRESC, mon_presc);
      apb_write(timer_pkg::REG_ARR, mon_arr);
      apb_write(timer_pkg::REG_CNT, 0);
      apb_write(timer_pkg::REG_CTRL, 1 << timer_pkg::CTRL_EN_BIT);
      mon_k = 0;
      mon_active = 1'b1;
      repeat (mon_presc + 5) @(negedge clk);
      mon_active = 1'b0;
      mon_load = $urandom % (mon_arr + 1);
      apb_write(timer_pkg::REG_CNT, mon_load);
      mon_k = 0;
      mon_active = 1'b1;
      repeat ((mon_presc + 1) * (mon_arr + 1) + 3) @(negedge clk);
      // access cycle of the next write ends three edges from here
      mon_stop_k = mon_k + 3;
      apb_write(timer_pkg::REG_CTRL, 0);
      repeat (6) @(negedge clk);
      mon_active = 1'b0;
      read_check(timer_pkg::REG_CNT,
                 expected_count(mon_load, mon_presc, mon_arr, mon_stop_k + 1), "prdata CNT");
      check_word("count", expected_count(mon_load, mon_presc, mon_arr, mon_stop_k + 1), count);

      $display("checks finished with %0d errors", errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
